/* src/hazard_params.svh */
`ifndef HAZARD_PARAMS_SVH
`define HAZARD_PARAMS_SVH

// opcode field, top six bits
`define HZ_OP_MSB 31
`define HZ_OP_LSB 26

// register fields, mips layout
`define HZ_RS_MSB 25
`define HZ_RS_LSB 21
`define HZ_RT_MSB 20
`define HZ_RT_LSB 16
`define HZ_RD_MSB 15
`define HZ_RD_LSB 11

// funct field, only meaningful when opcode is zero
`define HZ_FUNCT_MSB 5
`define HZ_FUNCT_LSB 0

// all-zero word, also decodes as a harmless shift
`define HZ_NOP_INSTR 32'h0000_0000
// hardwired zero register
`define HZ_ZERO_REG 5'd0
// seq number fetch puts on an empty slot so it sorts last
`define HZ_NULL_SEQ 16'h7FFF

`endif

/* src/hazard_pkg.sv */
`default_nettype none

package hazard_pkg;

    // raw instruction word
    typedef logic [31:0] instr_t;

    // program counter as fetch sends it
    typedef logic [31:0] pc_t;

    // fetch order tag, lower issues first
    typedef logic [15:0] seq_t;

    // one of 32 architectural registers
    typedef logic [4:0] reg_idx_t;

    // decode fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

    // operand layout of an instruction
    // r_type   rd <- rs, rt
    // shift    rd <- rt
    // i_type   rt <- rs
    typedef enum logic [1:0] {
        r_type = 2'd0,
        shift  = 2'd1,
        i_type = 2'd2
    } instr_class_e;

endpackage

`default_nettype wire

/* src/bundle_sorter.sv */
`timescale 1ns/1ps
`default_nettype none

module bundle_sorter
    import hazard_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     load,
    input  wire instr_t   alpha_inst,
    input  wire instr_t   beta_inst,
    input  wire instr_t   gamma_inst,
    input  wire seq_t     alpha_seq,
    input  wire seq_t     beta_seq,
    input  wire seq_t     gamma_seq,
    input  wire pc_t      alpha_pc,
    input  wire pc_t      beta_pc,
    input  wire pc_t      gamma_pc,
    input  wire reg_idx_t pipe_a_dest,
    input  wire reg_idx_t pipe_b_dest,
    input  wire reg_idx_t pipe_c_dest,
    output instr_t        first_inst,
    output instr_t        second_inst,
    output instr_t        third_inst,
    output pc_t           first_pc,
    output pc_t           second_pc,
    output pc_t           third_pc,
    output reg_idx_t      held_a_dest,
    output reg_idx_t      held_b_dest,
    output reg_idx_t      held_c_dest
);

    // captured bundle, index 0 alpha, 1 beta, 2 gamma
    instr_t cap_inst [3];
    seq_t   cap_seq  [3];
    pc_t    cap_pc   [3];

    // pairwise order, ties go to the lower slot index
    logic a_before_b;
    logic a_before_g;
    logic b_before_g;

    // 0 means issued first
    logic [1:0] rank_alpha;
    logic [1:0] rank_beta;
    logic [1:0] rank_gamma;

    // slot index feeding each ordered position
    logic [1:0] idx_first;
    logic [1:0] idx_second;
    logic [1:0] idx_third;

    // hold the bundle for the whole transaction
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 3; i++) begin
                cap_inst[i] <= '0;
                cap_seq[i]  <= '0;
                cap_pc[i]   <= '0;
            end
            held_a_dest <= '0;
            held_b_dest <= '0;
            held_c_dest <= '0;
        end else if (load) begin
            cap_inst[0] <= alpha_inst;
            cap_inst[1] <= beta_inst;
            cap_inst[2] <= gamma_inst;
            cap_seq[0]  <= alpha_seq;
            cap_seq[1]  <= beta_seq;
            cap_seq[2]  <= gamma_seq;
            cap_pc[0]   <= alpha_pc;
            cap_pc[1]   <= beta_pc;
            cap_pc[2]   <= gamma_pc;
            // pipeline state snapshot goes with the bundle
            held_a_dest <= pipe_a_dest;
            held_b_dest <= pipe_b_dest;
            held_c_dest <= pipe_c_dest;
        end
    end

    // <= so equal tags keep alpha, beta, gamma order
    assign a_before_b = (cap_seq[0] <= cap_seq[1]);
    assign a_before_g = (cap_seq[0] <= cap_seq[2]);
    assign b_before_g = (cap_seq[1] <= cap_seq[2]);

    // rank is the count of slots ahead of this one
    assign rank_alpha = {1'b0, ~a_before_b} + {1'b0, ~a_before_g};
    assign rank_beta  = {1'b0, a_before_b} + {1'b0, ~b_before_g};
    assign rank_gamma = {1'b0, a_before_g} + {1'b0, b_before_g};

    // ranks form a permutation, gamma is the fallback
    assign idx_first  = (rank_alpha == 2'd0) ? 2'd0 : (rank_beta == 2'd0) ? 2'd1 : 2'd2;
    assign idx_second = (rank_alpha == 2'd1) ? 2'd0 : (rank_beta == 2'd1) ? 2'd1 : 2'd2;
    assign idx_third  = (rank_alpha == 2'd2) ? 2'd0 : (rank_beta == 2'd2) ? 2'd1 : 2'd2;

    assign first_inst  = cap_inst[idx_first];
    assign second_inst = cap_inst[idx_second];
    assign third_inst  = cap_inst[idx_third];
    assign first_pc    = cap_pc[idx_first];
    assign second_pc   = cap_pc[idx_second];
    assign third_pc    = cap_pc[idx_third];

endmodule

`default_nettype wire

/* src/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module instr_decode
    import hazard_pkg::*;
(
    input  wire instr_t inst,
    output reg_idx_t    dest,
    output reg_idx_t    src1,
    output reg_idx_t    src2,
    output logic        has_src2
);

    opcode_t      opcode;
    funct_t       funct;
    reg_idx_t     rs;
    reg_idx_t     rt;
    reg_idx_t     rd;
    instr_class_e iclass;

    // raw field split
    assign opcode = inst[`HZ_OP_MSB:`HZ_OP_LSB];
    assign funct  = inst[`HZ_FUNCT_MSB:`HZ_FUNCT_LSB];
    assign rs     = inst[`HZ_RS_MSB:`HZ_RS_LSB];
    assign rt     = inst[`HZ_RT_MSB:`HZ_RT_LSB];
    assign rd     = inst[`HZ_RD_MSB:`HZ_RD_LSB];

    // any nonzero opcode is immediate form
    // zero funct under zero opcode is a shift, NOP included
    assign iclass = (opcode != '0) ? i_type :
                    (funct != '0)  ? r_type : shift;

    always_comb begin
        // single-source layout unless r_type
        dest     = rt;
        src1     = rs;
        src2     = `HZ_ZERO_REG;
        has_src2 = 1'b0;
        case (iclass)
            r_type: begin
                dest     = rd;
                src1     = rs;
                src2     = rt;
                has_src2 = 1'b1;
            end
            shift: begin
                // rs bits unused by shifts
                dest = rd;
                src1 = rt;
            end
            default: begin
                // i_type writes rt, rd bits are immediate
                dest = rt;
                src1 = rs;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/hazard_check.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module hazard_check
    import hazard_pkg::*;
(
    input  wire reg_idx_t dest1,
    input  wire reg_idx_t src1_1,
    input  wire reg_idx_t src2_1,
    input  wire logic     has_src2_1,
    input  wire reg_idx_t dest2,
    input  wire reg_idx_t src1_2,
    input  wire reg_idx_t src2_2,
    input  wire logic     has_src2_2,
    input  wire reg_idx_t dest3,
    input  wire reg_idx_t src1_3,
    input  wire reg_idx_t src2_3,
    input  wire logic     has_src2_3,
    input  wire reg_idx_t held_a_dest,
    input  wire reg_idx_t held_b_dest,
    input  wire reg_idx_t held_c_dest,
    output logic          stall1,
    output logic          stall2,
    output logic          stall3
);

    // r0 never carries a dependency
    function automatic logic same_reg(input reg_idx_t a, input reg_idx_t b);
        return (a != `HZ_ZERO_REG) && (a == b);
    endfunction

    // register still being written by one of the running pipes
    function automatic logic in_pipe(
        input reg_idx_t r,
        input reg_idx_t pa,
        input reg_idx_t pb,
        input reg_idx_t pc
    );
        return same_reg(r, pa) || same_reg(r, pb) || same_reg(r, pc);
    endfunction

    // later slot against an earlier one in the same bundle
    function automatic logic slot_dep(
        input reg_idx_t late_dest,
        input reg_idx_t late_src1,
        input reg_idx_t late_src2,
        input logic     late_has2,
        input reg_idx_t early_dest,
        input reg_idx_t early_src1,
        input reg_idx_t early_src2,
        input logic     early_has2
    );
        logic waw;
        logic war;
        logic raw;
        waw = same_reg(late_dest, early_dest);
        // overwriting something the earlier slot still reads
        war = same_reg(late_dest, early_src1) ||
              (early_has2 && same_reg(late_dest, early_src2));
        // reading what the earlier slot produces
        raw = same_reg(late_src1, early_dest) ||
              (late_has2 && same_reg(late_src2, early_dest));
        return waw || war || raw;
    endfunction

    logic pipe_hit1;
    logic pipe_hit2;
    logic pipe_hit3;
    logic dep_2_on_1;
    logic dep_3_on_1;
    logic dep_3_on_2;

    // every used field checked against all three pipes
    assign pipe_hit1 = in_pipe(dest1, held_a_dest, held_b_dest, held_c_dest) ||
                       in_pipe(src1_1, held_a_dest, held_b_dest, held_c_dest) ||
                       (has_src2_1 && in_pipe(src2_1, held_a_dest, held_b_dest, held_c_dest));
    assign pipe_hit2 = in_pipe(dest2, held_a_dest, held_b_dest, held_c_dest) ||
                       in_pipe(src1_2, held_a_dest, held_b_dest, held_c_dest) ||
                       (has_src2_2 && in_pipe(src2_2, held_a_dest, held_b_dest, held_c_dest));
    assign pipe_hit3 = in_pipe(dest3, held_a_dest, held_b_dest, held_c_dest) ||
                       in_pipe(src1_3, held_a_dest, held_b_dest, held_c_dest) ||
                       (has_src2_3 && in_pipe(src2_3, held_a_dest, held_b_dest, held_c_dest));

    // same rule for slot 2 and slot 3
    assign dep_2_on_1 = slot_dep(dest2, src1_2, src2_2, has_src2_2,
                                 dest1, src1_1, src2_1, has_src2_1);
    assign dep_3_on_1 = slot_dep(dest3, src1_3, src2_3, has_src2_3,
                                 dest1, src1_1, src2_1, has_src2_1);
    assign dep_3_on_2 = slot_dep(dest3, src1_3, src2_3, has_src2_3,
                                 dest2, src1_2, src2_2, has_src2_2);

    // in-order issue, a stall blocks everything behind it
    assign stall1 = pipe_hit1;
    assign stall2 = stall1 || pipe_hit2 || dep_2_on_1;
    assign stall3 = stall2 || pipe_hit3 || dep_3_on_1 || dep_3_on_2;

endmodule

`default_nettype wire

/* src/issue_result.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module issue_result
    import hazard_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   req,
    output logic        ack,
    output logic        load,
    input  wire instr_t first_inst,
    input  wire instr_t second_inst,
    input  wire instr_t third_inst,
    input  wire pc_t    first_pc,
    input  wire pc_t    second_pc,
    input  wire pc_t    third_pc,
    input  wire logic   stall1,
    input  wire logic   stall2,
    input  wire logic   stall3,
    output instr_t      inst1_out,
    output instr_t      inst2_out,
    output instr_t      inst3_out,
    output pc_t         pc1_out,
    output pc_t         pc2_out,
    output pc_t         pc3_out
);

    // idle waits for req, busy is the decode cycle, acked waits for req low
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_busy  = 2'd1,
        st_acked = 2'd2
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (req) state <= st_busy;
                st_busy:  state <= st_acked;
                st_acked: if (!req) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // sorter captures on the edge that sees this
    assign load = req && (state == st_idle);
    // four-phase ack, high until req drops
    assign ack  = (state == st_acked);

    // stalled slot returns NOP and its own pc for refetch
    // issued slot returns zero pc so fetch may move on
    always_ff @(posedge clk) begin
        if (reset) begin
            inst1_out <= '0;
            inst2_out <= '0;
            inst3_out <= '0;
            pc1_out   <= '0;
            pc2_out   <= '0;
            pc3_out   <= '0;
        end else if (state == st_busy) begin
            inst1_out <= stall1 ? `HZ_NOP_INSTR : first_inst;
            inst2_out <= stall2 ? `HZ_NOP_INSTR : second_inst;
            inst3_out <= stall3 ? `HZ_NOP_INSTR : third_inst;
            pc1_out   <= stall1 ? first_pc  : '0;
            pc2_out   <= stall2 ? second_pc : '0;
            pc3_out   <= stall3 ? third_pc  : '0;
        end
    end

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import hazard_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     req,
    input  wire instr_t   alpha_inst,
    input  wire instr_t   beta_inst,
    input  wire instr_t   gamma_inst,
    input  wire seq_t     alpha_seq,
    input  wire seq_t     beta_seq,
    input  wire seq_t     gamma_seq,
    input  wire pc_t      alpha_pc,
    input  wire pc_t      beta_pc,
    input  wire pc_t      gamma_pc,
    input  wire reg_idx_t pipe_a_dest,
    input  wire reg_idx_t pipe_b_dest,
    input  wire reg_idx_t pipe_c_dest,
    output logic          ack,
    output instr_t        inst1_out,
    output instr_t        inst2_out,
    output instr_t        inst3_out,
    output pc_t           pc1_out,
    output pc_t           pc2_out,
    output pc_t           pc3_out
);

    logic     load;
    // bundle in issue order
    instr_t   first_inst, second_inst, third_inst;
    pc_t      first_pc, second_pc, third_pc;
    // pipe state captured with the bundle
    reg_idx_t held_a_dest, held_b_dest, held_c_dest;
    // decoded operands per ordered slot
    reg_idx_t dest1, src1_1, src2_1;
    reg_idx_t dest2, src1_2, src2_2;
    reg_idx_t dest3, src1_3, src2_3;
    logic     has_src2_1, has_src2_2, has_src2_3;
    logic     stall1, stall2, stall3;

    // capture and order
    bundle_sorter u_sorter (
        .clk, .reset, .load,
        .alpha_inst, .beta_inst, .gamma_inst,
        .alpha_seq, .beta_seq, .gamma_seq,
        .alpha_pc, .beta_pc, .gamma_pc,
        .pipe_a_dest, .pipe_b_dest, .pipe_c_dest,
        .first_inst, .second_inst, .third_inst,
        .first_pc, .second_pc, .third_pc,
        .held_a_dest, .held_b_dest, .held_c_dest
    );

    // one decoder per ordered slot
    instr_decode u_dec1 (
        .inst(first_inst), .dest(dest1), .src1(src1_1), .src2(src2_1), .has_src2(has_src2_1)
    );
    instr_decode u_dec2 (
        .inst(second_inst), .dest(dest2), .src1(src1_2), .src2(src2_2), .has_src2(has_src2_2)
    );
    instr_decode u_dec3 (
        .inst(third_inst), .dest(dest3), .src1(src1_3), .src2(src2_3), .has_src2(has_src2_3)
    );

    hazard_check u_check (
        .dest1, .src1_1, .src2_1, .has_src2_1,
        .dest2, .src1_2, .src2_2, .has_src2_2,
        .dest3, .src1_3, .src2_3, .has_src2_3,
        .held_a_dest, .held_b_dest, .held_c_dest,
        .stall1, .stall2, .stall3
    );

    // handshake and registered outputs
    issue_result u_result (
        .clk, .reset, .req, .ack, .load,
        .first_inst, .second_inst, .third_inst,
        .first_pc, .second_pc, .third_pc,
        .stall1, .stall2, .stall3,
        .inst1_out, .inst2_out, .inst3_out,
        .pc1_out, .pc2_out, .pc3_out
    );

endmodule

`default_nettype wire

/* test/tb_hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "hazard_params.svh"

module tb_hazard_unit
    import hazard_pkg::*;
();

    localparam int NROWS          = 19;
    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_ROW = 20;

    logic     clk;
    logic     reset;
    logic     req;
    instr_t   alpha_inst, beta_inst, gamma_inst;
    seq_t     alpha_seq, beta_seq, gamma_seq;
    pc_t      alpha_pc, beta_pc, gamma_pc;
    reg_idx_t pipe_a_dest, pipe_b_dest, pipe_c_dest;
    logic     ack;
    instr_t   inst1_out, inst2_out, inst3_out;
    pc_t      pc1_out, pc2_out, pc3_out;

    // per row the alpha, beta and gamma slots and the pipe dests
    instr_t   tab_inst  [NROWS][3];
    seq_t     tab_seq   [NROWS][3];
    reg_idx_t tab_pipe  [NROWS][3];
    // expected issue order as slot index
    // stall bit k belongs to ordered slot k
    int       tab_order [NROWS][3];
    logic [2:0] tab_stall [NROWS];

    int n_rows;
    int cur_row;
    // 1 while waiting for ack to rise and 2 while waiting for it to fall
    int phase;

    hazard_unit u_dut (
        .clk, .reset, .req,
        .alpha_inst, .beta_inst, .gamma_inst,
        .alpha_seq, .beta_seq, .gamma_seq,
        .alpha_pc, .beta_pc, .gamma_pc,
        .pipe_a_dest, .pipe_b_dest, .pipe_c_dest,
        .ack,
        .inst1_out, .inst2_out, .inst3_out,
        .pc1_out, .pc2_out, .pc3_out
    );

    always #5 clk = ~clk;

    // bound on the whole run since a row needs about six cycles
    initial begin
        #((NROWS * CYCLES_PER_ROW + RESET_CYCLES + 4) * 10);
        if (phase == 1)
            $display("timeout: ack never arrived for row %0d", cur_row);
        else if (phase == 2)
            $display("timeout: ack never fell for row %0d", cur_row);
        else
            $display("timeout: run did not reach its end");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    // instruction encoders in mips field layout
    function automatic instr_t r_word(input reg_idx_t rs, input reg_idx_t rt,
                                      input reg_idx_t rd, input funct_t fn);
        return {6'd0, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instr_t shift_word(input reg_idx_t rs, input reg_idx_t rt,
                                          input reg_idx_t rd, input logic [4:0] shamt);
        return {6'd0, rs, rt, rd, shamt, 6'd0};
    endfunction

    function automatic instr_t imm_word(input opcode_t op, input reg_idx_t rs,
                                        input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // fixed pc per fetch slot
    function automatic pc_t slot_pc(input int s);
        return pc_t'(32'h0000_0100 + 4 * s);
    endfunction

    task automatic check_instr(input instr_t got, input instr_t exp, input int slot);
        if (got !== exp) begin
            $display("FAILED at %0t: row %0d slot %0d instruction got %h expected %h",
                     $time, cur_row, slot, got, exp);
            $display("Done: errors found");
            $fatal(1, "instruction mismatch");
        end
    endtask

    task automatic check_pc(input pc_t got, input pc_t exp, input int slot);
        if (got !== exp) begin
            $display("FAILED at %0t: row %0d slot %0d pc got %h expected %h",
                     $time, cur_row, slot, got, exp);
            $display("Done: errors found");
            $fatal(1, "pc mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: row %0d %s got %b expected %b",
                     $time, cur_row, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "ack mismatch");
        end
    endtask

    task automatic check_latency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED at %0t: row %0d %s took %0d edges expected %0d",
                     $time, cur_row, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "handshake latency mismatch");
        end
    endtask

    task automatic add_row(input instr_t ia, ib, ig, input seq_t sa, sb, sg,
                           input reg_idx_t pa, pb, pg, input int o1, o2, o3,
                           input logic [2:0] st);
        tab_inst[n_rows]  = '{ia, ib, ig};
        tab_seq[n_rows]   = '{sa, sb, sg};
        tab_pipe[n_rows]  = '{pa, pb, pg};
        tab_order[n_rows] = '{o1, o2, o3};
        tab_stall[n_rows] = st;
        n_rows++;
    endtask

    task automatic build_table();
        instr_t a, b, c, b_raw, c_raw, s_hit, s_rs, i_rd, z1, z2, nop;
        // independent r_types with no shared registers
        a     = r_word(5'd1, 5'd2, 5'd3, 6'h20);
        b     = r_word(5'd4, 5'd5, 5'd6, 6'h22);
        c     = r_word(5'd7, 5'd8, 5'd9, 6'h24);
        b_raw = r_word(5'd3, 5'd5, 5'd6, 6'h20);
        c_raw = r_word(5'd7, 5'd6, 5'd9, 6'h20);
        // shift writes rd and ignores its rs bits
        s_hit = shift_word(5'd0, 5'd14, 5'd13, 5'd2);
        s_rs  = shift_word(5'd13, 5'd14, 5'd15, 5'd2);
        // load with immediate bits sitting on register 13
        i_rd  = imm_word(6'h23, 5'd16, 5'd17, 16'h6800);
        z1    = r_word(5'd0, 5'd0, 5'd0, 6'h20);
        z2    = r_word(5'd0, 5'd0, 5'd0, 6'h21);
        nop   = `HZ_NOP_INSTR;
        n_rows = 0;
        // every seq permutation and then ties
        add_row(a, b, c, 16'd1, 16'd2, 16'd3, 5'd20, 5'd21, 5'd22, 0, 1, 2, 3'b000);
        add_row(a, b, c, 16'd1, 16'd3, 16'd2, 5'd20, 5'd21, 5'd22, 0, 2, 1, 3'b000);
        add_row(a, b, c, 16'd2, 16'd1, 16'd3, 5'd20, 5'd21, 5'd22, 1, 0, 2, 3'b000);
        add_row(a, b, c, 16'd2, 16'd3, 16'd1, 5'd20, 5'd21, 5'd22, 2, 0, 1, 3'b000);
        add_row(a, b, c, 16'd3, 16'd1, 16'd2, 5'd20, 5'd21, 5'd22, 1, 2, 0, 3'b000);
        add_row(a, b, c, 16'd3, 16'd2, 16'd1, 5'd20, 5'd21, 5'd22, 2, 1, 0, 3'b000);
        add_row(a, b, c, 16'd5, 16'd5, 16'd5, 5'd20, 5'd21, 5'd22, 0, 1, 2, 3'b000);
        add_row(a, b, c, 16'd5, 16'd5, 16'd3, 5'd20, 5'd21, 5'd22, 2, 0, 1, 3'b000);
        add_row(a, b, c, 16'd2, 16'd7, 16'd2, 5'd20, 5'd21, 5'd22, 0, 2, 1, 3'b000);
        // first slot reads pipe b dest so the whole bundle stalls
        add_row(a, b, c, 16'd1, 16'd2, 16'd3, 5'd20, 5'd1, 5'd22, 0, 1, 2, 3'b111);
        // gamma issues first and its rt field hits the pipe c dest
        add_row(a, b, c, 16'd2, 16'd3, 16'd1, 5'd20, 5'd21, 5'd8, 2, 0, 1, 3'b111);
        // raw inside the bundle
        add_row(a, b_raw, c, 16'd1, 16'd2, 16'd3, 5'd20, 5'd21, 5'd22, 0, 1, 2, 3'b110);
        add_row(a, b, c_raw, 16'd1, 16'd2, 16'd3, 5'd20, 5'd21, 5'd22, 0, 1, 2, 3'b100);
        // decode class field routing
        add_row(a, b, s_hit, 16'd1, 16'd2, 16'd3, 5'd13, 5'd21, 5'd22, 0, 1, 2, 3'b100);
        add_row(a, b, s_rs, 16'd1, 16'd2, 16'd3, 5'd13, 5'd21, 5'd22, 0, 1, 2, 3'b000);
        add_row(a, b, i_rd, 16'd1, 16'd2, 16'd3, 5'd13, 5'd21, 5'd22, 0, 1, 2, 3'b000);
        // empty slots sort last and r0 never hits
        add_row(nop, a, nop, `HZ_NULL_SEQ, 16'd4, `HZ_NULL_SEQ, 5'd0, 5'd0, 5'd0,
                1, 0, 2, 3'b000);
        add_row(nop, nop, nop, `HZ_NULL_SEQ, `HZ_NULL_SEQ, `HZ_NULL_SEQ, 5'd0, 5'd0, 5'd0,
                0, 1, 2, 3'b000);
        add_row(z1, z2, nop, 16'd1, 16'd2, `HZ_NULL_SEQ, 5'd0, 5'd0, 5'd0, 0, 1, 2, 3'b000);
    endtask

    task automatic compare_outputs(input int r);
        instr_t exp_inst [3];
        pc_t    exp_pc   [3];
        // stalled slot comes back as nop with its own pc
        for (int k = 0; k < 3; k++) begin
            exp_inst[k] = tab_stall[r][k] ? `HZ_NOP_INSTR : tab_inst[r][tab_order[r][k]];
            exp_pc[k]   = tab_stall[r][k] ? slot_pc(tab_order[r][k]) : '0;
        end
        check_instr(inst1_out, exp_inst[0], 1);
        check_instr(inst2_out, exp_inst[1], 2);
        check_instr(inst3_out, exp_inst[2], 3);
        check_pc(pc1_out, exp_pc[0], 1);
        check_pc(pc2_out, exp_pc[1], 2);
        check_pc(pc3_out, exp_pc[2], 3);
    endtask

    // one four-phase transaction started on a falling edge
    task automatic apply_row(input int r);
        int edges;
        alpha_inst  = tab_inst[r][0];
        beta_inst   = tab_inst[r][1];
        gamma_inst  = tab_inst[r][2];
        alpha_seq   = tab_seq[r][0];
        beta_seq    = tab_seq[r][1];
        gamma_seq   = tab_seq[r][2];
        pipe_a_dest = tab_pipe[r][0];
        pipe_b_dest = tab_pipe[r][1];
        pipe_c_dest = tab_pipe[r][2];
        req   = 1'b1;
        phase = 1;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (!ack);
        // load edge, then result edge
        check_latency(edges, 2, "req to ack");
        compare_outputs(r);
        // scramble the bundle while the outputs must hold
        alpha_inst  = ~alpha_inst;
        gamma_inst  = ~gamma_inst;
        alpha_seq   = ~alpha_seq;
        beta_pc     = ~beta_pc;
        pipe_a_dest = ~pipe_a_dest;
        repeat (2) @(negedge clk);
        check_flag(ack, 1'b1, "ack while req high");
        compare_outputs(r);
        req   = 1'b0;
        phase = 2;
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (ack);
        check_latency(edges, 1, "req low to ack low");
        phase = 0;
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        alpha_inst  = '0;
        beta_inst   = '0;
        gamma_inst  = '0;
        alpha_seq   = '0;
        beta_seq    = '0;
        gamma_seq   = '0;
        alpha_pc    = slot_pc(0);
        beta_pc     = slot_pc(1);
        gamma_pc    = slot_pc(2);
        pipe_a_dest = '0;
        pipe_b_dest = '0;
        pipe_c_dest = '0;
        phase       = 0;
        cur_row     = -1;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        check_flag(ack, 1'b0, "ack after reset");
        check_instr(inst1_out, '0, 1);
        check_instr(inst2_out, '0, 2);
        check_instr(inst3_out, '0, 3);
        check_pc(pc1_out, '0, 1);
        check_pc(pc2_out, '0, 2);
        check_pc(pc3_out, '0, 3);
        for (int r = 0; r < n_rows; r++) begin
            cur_row  = r;
            beta_pc  = slot_pc(1);
            apply_row(r);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/hazard_pkg.sv
src/bundle_sorter.sv
src/instr_decode.sv
src/hazard_check.sv
src/issue_result.sv
src/hazard_unit.sv
test/tb_hazard_unit.sv

/* Makefile */
SRCS := $(shell grep '\.sv$$' all.f) $(wildcard src/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_hazard_unit
	@out="$$(./obj_dir/Vtb_hazard_unit)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

obj_dir/Vtb_hazard_unit: all.f $(SRCS)
	verilator --binary --timing -f all.f --top-module tb_hazard_unit -o Vtb_hazard_unit

clean:
	rm -rf obj_dir
